//--- Bender.yml
package:
  name: tile_mem_fabric

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_fabric_pkg.sv
      - hdl/mem_cmd_demux.sv
      - hdl/mem_resp_arbiter.sv
      - hdl/cfg_regs.sv
      - hdl/clint_slice.sv
      - hdl/mem_loopback.sv
      - hdl/tile_mem_fabric.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/mem_fabric_assertions.sv
      - dv/mem_fabric_checker.sv
      - dv/tb_tile_mem_fabric.sv

//--- dv/mem_fabric_assertions.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module mem_fabric_assertions
  import mem_fabric_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input mem_hdr_s cmd_hdr_i,
  input logic     ext_cmd_v_i,
  input mem_hdr_s resp_hdr_i,
  input logic     resp_v_i,
  input logic     resp_yumi_i,
  input logic     timer_irq_i,
  input logic     software_irq_i
);

  logic local_non_cache;

  assign local_non_cache = (cmd_hdr_i.addr.flat < `MF_DRAM_BASE)
                         & (cmd_hdr_i.addr.loc.dev_id != `MF_CACHE_DEV);

  // ==============================
  // Response and routing rules
  // ==============================
  resp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i && !resp_yumi_i |=> resp_v_i && $stable(resp_hdr_i))
    else $error("response valid dropped or header changed before yumi");

  ext_only_mapped: assert property (@(posedge clk_i) disable iff (reset_i)
    ext_cmd_v_i |-> !local_non_cache)
    else $error("local non-cache address reached the external port");

  irq_quiet_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !timer_irq_i && !software_irq_i)
    else $error("interrupt high in the first cycle after reset");

endmodule

bind tile_mem_fabric mem_fabric_assertions assertions
  (.clk_i(clk_i), .reset_i(reset_i), .cmd_hdr_i(mem_cmd_hdr_i), .ext_cmd_v_i(ext_cmd_v_o)
   ,.resp_hdr_i(mem_resp_hdr_o), .resp_v_i(mem_resp_v_o), .resp_yumi_i(mem_resp_yumi_i)
   ,.timer_irq_i(timer_irq_o), .software_irq_i(software_irq_o));

//--- dv/mem_fabric_checker.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module mem_fabric_checker
  import mem_fabric_pkg::*;
#(
  parameter logic [`MF_DATA_WIDTH-1:0] EXT_PATTERN = '0
)
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_hdr_s                  cmd_hdr_i,
  input  logic [`MF_DATA_WIDTH-1:0] cmd_data_i,
  input  logic                      cmd_v_i,
  input  logic                      cmd_ready_i,
  input  mem_hdr_s                  resp_hdr_i,
  input  logic [`MF_DATA_WIDTH-1:0] resp_data_i,
  input  logic                      resp_v_i,
  input  logic                      resp_yumi_i,
  input  mem_hdr_s                  ext_cmd_hdr_i,
  input  logic [`MF_DATA_WIDTH-1:0] ext_cmd_data_i,
  input  logic                      ext_cmd_v_i,
  input  logic                      freeze_i,
  input  logic                      timer_irq_i,
  input  logic                      software_irq_i,
  output int                        err_count_o
);

  logic                      sh_freeze;
  logic [`MF_DATA_WIDTH-1:0] sh_scratch;
  logic                      sh_msip;
  logic [`MF_DATA_WIDTH-1:0] sh_mtimecmp;
  logic [`MF_DATA_WIDTH-1:0] sh_mtime;
  logic                      mtime_wr;
  logic                      armed = 1'b0;
  int                        errors = 0;
  mem_hdr_s                  exp_hdr_q [$];
  logic [`MF_DATA_WIDTH-1:0] exp_data_q [$];
  mem_hdr_s                  exp_hdr;
  logic [`MF_DATA_WIDTH-1:0] exp_data;

  assign err_count_o = errors;

  function automatic logic goes_external(input mem_addr_u a);
    return (a.flat >= `MF_DRAM_BASE) || (a.loc.dev_id == `MF_CACHE_DEV);
  endfunction

  // Reference model of the response data
  function automatic logic [`MF_DATA_WIDTH-1:0] expected_data(input mem_hdr_s hdr);
    logic [`MF_DATA_WIDTH-1:0] result;
    result = '0;   // Writes and unmapped reads
    if (hdr.opcode == e_mem_rd)
    begin
      if (goes_external(hdr.addr))
        result = {32'h0, hdr.addr.flat} ^ EXT_PATTERN;
      else if (hdr.addr.loc.dev_id == `MF_CFG_DEV)
      begin
        if (hdr.addr.loc.offset == `MF_CFG_FREEZE_OFS)
          result = {63'h0, sh_freeze};
        else if (hdr.addr.loc.offset == `MF_CFG_SCRATCH_OFS)
          result = sh_scratch;
      end
      else if (hdr.addr.loc.dev_id == `MF_CLINT_DEV)
      begin
        if (hdr.addr.loc.offset == `MF_CLINT_MSIP_OFS)
          result = {63'h0, sh_msip};
        else if (hdr.addr.loc.offset == `MF_CLINT_MTIMECMP_OFS)
          result = sh_mtimecmp;
        else if (hdr.addr.loc.offset == `MF_CLINT_MTIME_OFS)
          result = sh_mtime;
      end
    end
    return result;
  endfunction

  task automatic compare(input string sig, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("error at %0t ns: %s expected %h, actual %h", $time, sig, exp, act);
      errors++;
    end
  endtask

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      sh_freeze   = 1'b1;
      sh_scratch  = '0;
      sh_msip     = 1'b0;
      sh_mtimecmp = '1;
      sh_mtime    = '0;
      exp_hdr_q.delete();
      exp_data_q.delete();
      armed       = 1'b1;
    end
    else if (armed)
    begin
      // ==============================
      // Levels and routing
      // ==============================
      compare("freeze_o", sh_freeze, freeze_i);
      compare("software_irq_o", sh_msip, software_irq_i);
      compare("timer_irq_o", sh_mtime >= sh_mtimecmp, timer_irq_i);
      if (cmd_v_i)
        compare("ext_cmd_v_o", goes_external(cmd_hdr_i.addr), ext_cmd_v_i);
      if (cmd_v_i && ext_cmd_v_i)
      begin
        compare("ext_cmd_hdr_o", cmd_hdr_i, ext_cmd_hdr_i);
        compare("ext_cmd_data_o", cmd_data_i, ext_cmd_data_i);
      end

      if (resp_v_i && resp_yumi_i)
      begin
        if (exp_hdr_q.size() == 0)
        begin
          $display("response popped at %0t ns with no command outstanding", $time);
          errors++;
        end
        else
        begin
          exp_hdr  = exp_hdr_q.pop_front();
          exp_data = exp_data_q.pop_front();
          compare("mem_resp_hdr_o", exp_hdr, resp_hdr_i);
          compare("mem_resp_data_o", exp_data, resp_data_i);
        end
      end

      // Expected value taken before the write lands
      mtime_wr = 1'b0;
      if (cmd_v_i && cmd_ready_i)
      begin
        exp_hdr_q.push_back(cmd_hdr_i);
        exp_data_q.push_back(expected_data(cmd_hdr_i));
        if (cmd_hdr_i.opcode == e_mem_wr && !goes_external(cmd_hdr_i.addr))
        begin
          if (cmd_hdr_i.addr.loc.dev_id == `MF_CFG_DEV)
          begin
            if (cmd_hdr_i.addr.loc.offset == `MF_CFG_FREEZE_OFS)
              sh_freeze = cmd_data_i[0];
            if (cmd_hdr_i.addr.loc.offset == `MF_CFG_SCRATCH_OFS)
              sh_scratch = cmd_data_i;
          end
          if (cmd_hdr_i.addr.loc.dev_id == `MF_CLINT_DEV)
          begin
            if (cmd_hdr_i.addr.loc.offset == `MF_CLINT_MSIP_OFS)
              sh_msip = cmd_data_i[0];
            if (cmd_hdr_i.addr.loc.offset == `MF_CLINT_MTIMECMP_OFS)
              sh_mtimecmp = cmd_data_i;
            if (cmd_hdr_i.addr.loc.offset == `MF_CLINT_MTIME_OFS)
            begin
              sh_mtime = cmd_data_i;
              mtime_wr = 1'b1;
            end
          end
        end
      end
      if (!mtime_wr)
        sh_mtime = sh_mtime + 1;   // Timer ticks every cycle
    end
  end

endmodule

//--- dv/tb_tile_mem_fabric.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module tb_tile_mem_fabric
  import mem_fabric_pkg::*;
();

  localparam int                        TIMEOUT     = 200;
  localparam int                        EXT_LATENCY = 3;
  localparam logic [`MF_DATA_WIDTH-1:0] EXT_PATTERN = 64'hA5C3_5A3C_0FF0_F00F;

  logic                      clk_i;
  logic                      reset_i;
  mem_hdr_s                  mem_cmd_hdr_i;
  logic [`MF_DATA_WIDTH-1:0] mem_cmd_data_i;
  logic                      mem_cmd_v_i;
  logic                      mem_cmd_ready_o;
  mem_hdr_s                  mem_resp_hdr_o;
  logic [`MF_DATA_WIDTH-1:0] mem_resp_data_o;
  logic                      mem_resp_v_o;
  logic                      mem_resp_yumi_i;
  mem_hdr_s                  ext_cmd_hdr_o;
  logic [`MF_DATA_WIDTH-1:0] ext_cmd_data_o;
  logic                      ext_cmd_v_o;
  logic                      ext_cmd_ready_i;
  mem_hdr_s                  ext_resp_hdr_i;
  logic [`MF_DATA_WIDTH-1:0] ext_resp_data_i;
  logic                      ext_resp_v_i;
  logic                      ext_resp_yumi_o;
  logic                      freeze_o;
  logic                      timer_irq_o;
  logic                      software_irq_o;
  int                        err_count;
  int                        tb_fails;
  int                        test_base;
  int                        tests_passed;
  int                        tests_failed;
  logic [31:0]               rng_state;
  logic                      ext_take;
  logic                      ext_popped;
  int                        ext_delay;

  tile_mem_fabric DUT (.*);

  mem_fabric_checker #(.EXT_PATTERN(EXT_PATTERN)) resp_checker
    (.clk_i(clk_i), .reset_i(reset_i), .cmd_hdr_i(mem_cmd_hdr_i), .cmd_data_i(mem_cmd_data_i)
     ,.cmd_v_i(mem_cmd_v_i), .cmd_ready_i(mem_cmd_ready_o), .resp_hdr_i(mem_resp_hdr_o)
     ,.resp_data_i(mem_resp_data_o), .resp_v_i(mem_resp_v_o), .resp_yumi_i(mem_resp_yumi_i)
     ,.ext_cmd_hdr_i(ext_cmd_hdr_o), .ext_cmd_data_i(ext_cmd_data_o)
     ,.ext_cmd_v_i(ext_cmd_v_o), .freeze_i(freeze_o)
     ,.timer_irq_i(timer_irq_o), .software_irq_i(software_irq_o), .err_count_o(err_count));

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ==============================
  // External memory model
  // ==============================
  initial
  begin
    ext_cmd_ready_i = 1'b1;
    ext_resp_v_i    = 1'b0;
    ext_resp_hdr_i  = '0;
    ext_resp_data_i = '0;
    ext_delay       = 0;
    forever
    begin
      @(posedge clk_i);
      ext_take   = ext_cmd_v_o & ext_cmd_ready_i & mem_cmd_ready_o;
      ext_popped = ext_resp_v_i & ext_resp_yumi_o;
      #1;
      if (ext_popped)
      begin
        ext_resp_v_i    = 1'b0;
        ext_cmd_ready_i = 1'b1;
      end
      if (ext_take)
      begin
        ext_cmd_ready_i = 1'b0;   // One request at a time
        ext_resp_hdr_i  = ext_cmd_hdr_o;
        ext_resp_data_i = (ext_cmd_hdr_o.opcode == e_mem_rd)
                        ? ({32'h0, ext_cmd_hdr_o.addr.flat} ^ EXT_PATTERN) : '0;
        ext_delay       = EXT_LATENCY;
      end
      else if (ext_delay > 0)
      begin
        ext_delay--;
        if (ext_delay == 0)
          ext_resp_v_i = 1'b1;
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] local_addr(input logic [3:0] dev, input logic [19:0] ofs);
    return {8'h00, dev, ofs};
  endfunction

  task automatic drive_cmd(input mem_opcode_e op, input logic [31:0] addr,
                           input logic [63:0] data, output logic done);
    int waited;
    waited = 0;
    done   = 1'b0;
    while (!mem_cmd_ready_o && waited < TIMEOUT)
    begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (mem_cmd_ready_o)
    begin
      mem_cmd_hdr_i.opcode    = op;   // Controller raises valid only while ready is high
      mem_cmd_hdr_i.addr.flat = addr;
      mem_cmd_data_i          = data;
      mem_cmd_v_i             = 1'b1;
      @(posedge clk_i);
      done = mem_cmd_ready_o;   // Valid and ready at this edge
      #1;
      mem_cmd_v_i = 1'b0;
    end
    if (!done)
    begin
      $display("timeout: command to address %h was never accepted", addr);
      tb_fails++;
    end
  endtask

  task automatic collect_resp();
    int waited;
    waited = 0;
    while (!mem_resp_v_o && waited < TIMEOUT)
    begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (mem_resp_v_o)
    begin
      mem_resp_yumi_i = 1'b1;
      @(posedge clk_i);
      #1;
      mem_resp_yumi_i = 1'b0;
    end
    else
    begin
      $display("timeout: no response arrived at the controller port");
      tb_fails++;
    end
  endtask

  task automatic access(input mem_opcode_e op, input logic [31:0] addr,
                        input logic [63:0] data);
    logic done;
    drive_cmd(op, addr, data, done);
    if (done)
      collect_resp();
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = err_count + tb_fails - test_base;
    if (errs == 0)
    begin
      $display("test %s: pass", name);
      tests_passed++;
    end
    else
    begin
      $display("test %s: FAIL with %0d errors", name, errs);
      tests_failed++;
    end
    test_base = err_count + tb_fails;
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic config_regs_test();
    logic [63:0] data;
    access(e_mem_rd, local_addr(`MF_CFG_DEV, `MF_CFG_FREEZE_OFS), '0);
    access(e_mem_wr, local_addr(`MF_CFG_DEV, `MF_CFG_FREEZE_OFS), 64'h0);
    access(e_mem_rd, local_addr(`MF_CFG_DEV, `MF_CFG_FREEZE_OFS), '0);
    for (int i = 0; i < 3; i++)
    begin
      data = {next_rand(), next_rand()};
      access(e_mem_wr, local_addr(`MF_CFG_DEV, `MF_CFG_SCRATCH_OFS), data);
      access(e_mem_rd, local_addr(`MF_CFG_DEV, `MF_CFG_SCRATCH_OFS), '0);
    end
    access(e_mem_rd, local_addr(`MF_CFG_DEV, 20'h0_0010), '0);   // Unused offset
    report_test("config");
  endtask

  task automatic routing_test();
    logic [31:0] r;
    logic [31:0] addr;
    access(e_mem_rd, `MF_DRAM_BASE, '0);
    for (int i = 0; i < 3; i++)
    begin
      r    = next_rand();
      addr = {1'b1, r[30:0]};
      access(e_mem_wr, addr, {next_rand(), next_rand()});
      access(e_mem_rd, addr, '0);
      r    = next_rand();
      addr = {1'b0, r[6:0], `MF_CACHE_DEV, r[27:8]};   // Cache id
      access(e_mem_wr, addr, {next_rand(), next_rand()});
      access(e_mem_rd, addr, '0);
    end
    report_test("routing");
  endtask

  task automatic loopback_test();
    logic [31:0] r;
    logic [3:0]  dev;
    logic [31:0] addr;
    for (int i = 0; i < 4; i++)
    begin
      r    = next_rand();
      dev  = (i == 0) ? 4'd0 : 4'(4 + (next_rand() % 12));
      addr = {1'b0, r[6:0], dev, r[27:8]};
      access(e_mem_wr, addr, {next_rand(), next_rand()});
      access(e_mem_rd, addr, '0);
    end
    report_test("loopback");
  endtask

  task automatic interrupt_test();
    logic [63:0] cmp;
    cmp = {32'hFFFF_FF00, next_rand()};
    access(e_mem_wr, local_addr(`MF_CLINT_DEV, `MF_CLINT_MSIP_OFS), 64'h1);
    access(e_mem_rd, local_addr(`MF_CLINT_DEV, `MF_CLINT_MSIP_OFS), '0);
    access(e_mem_wr, local_addr(`MF_CLINT_DEV, `MF_CLINT_MSIP_OFS), 64'h0);
    access(e_mem_wr, local_addr(`MF_CLINT_DEV, `MF_CLINT_MTIMECMP_OFS), cmp);
    access(e_mem_rd, local_addr(`MF_CLINT_DEV, `MF_CLINT_MTIMECMP_OFS), '0);
    access(e_mem_rd, local_addr(`MF_CLINT_DEV, `MF_CLINT_MTIME_OFS), '0);
    access(e_mem_wr, local_addr(`MF_CLINT_DEV, `MF_CLINT_MTIMECMP_OFS), 64'h0);
    repeat (3) @(posedge clk_i);   // Let the timer level settle
    #1;
    report_test("interrupts");
  endtask

  task automatic backpressure_test();
    logic done;
    int   waited;
    drive_cmd(e_mem_rd, local_addr(`MF_CFG_DEV, `MF_CFG_SCRATCH_OFS), '0, done);
    drive_cmd(e_mem_rd, local_addr(`MF_CLINT_DEV, `MF_CLINT_MTIMECMP_OFS), '0, done);
    drive_cmd(e_mem_rd, local_addr(`MF_CFG_DEV, `MF_CFG_FREEZE_OFS), '0, done);
    waited = 0;
    while (mem_cmd_ready_o && waited < TIMEOUT)
    begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (mem_cmd_ready_o)
    begin
      $display("mem_cmd_ready_o stayed high while responses were held back");
      tb_fails++;
    end
    repeat (3) collect_resp();
    report_test("backpressure");
  endtask

  initial
  begin
    rng_state       = 32'h9624;
    tb_fails        = 0;
    test_base       = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    reset_i         = 1'b1;
    mem_cmd_hdr_i   = '0;
    mem_cmd_data_i  = '0;
    mem_cmd_v_i     = 1'b0;
    mem_resp_yumi_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    config_regs_test();
    routing_test();
    loopback_test();
    interrupt_test();
    backpressure_test();
    $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed,
             err_count + tb_fails);
    if (tests_failed == 0 && err_count + tb_fails == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- hdl/cfg_regs.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module cfg_regs
  import mem_fabric_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_hdr_s                  cmd_hdr_i,
  input  logic [`MF_DATA_WIDTH-1:0] cmd_data_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  output mem_hdr_s                  resp_hdr_o,
  output logic [`MF_DATA_WIDTH-1:0] resp_data_o,
  output logic                      resp_v_o,
  input  logic                      resp_yumi_i,
  output logic                      freeze_o
);

  logic                            freeze_r;
  logic [`MF_DATA_WIDTH-1:0]       scratch_r;
  logic                            resp_v_r;
  mem_hdr_s                        resp_hdr_r;
  logic [`MF_DATA_WIDTH-1:0]       resp_data_r;
  logic                            accept;
  logic                            is_wr;
  logic [`MF_DEV_OFFSET_WIDTH-1:0] ofs;
  logic [`MF_DATA_WIDTH-1:0]       rd_data;

  assign cmd_ready_o = ~resp_v_r;   // One response in flight
  assign accept      = cmd_v_i & ~resp_v_r;
  assign is_wr       = cmd_hdr_i.opcode == e_mem_wr;
  assign ofs         = cmd_hdr_i.addr.loc.offset;

  always_comb
  begin
    case (ofs)
      `MF_CFG_FREEZE_OFS:  rd_data = {{(`MF_DATA_WIDTH-1){1'b0}}, freeze_r};
      `MF_CFG_SCRATCH_OFS: rd_data = scratch_r;
      default:             rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r  <= 1'b0;
      freeze_r  <= 1'b1;   // Tile starts frozen
      scratch_r <= '0;
    end
    else
    begin
      resp_v_r <= (resp_v_r & ~resp_yumi_i) | accept;
      if (accept && is_wr && (ofs == `MF_CFG_FREEZE_OFS))
        freeze_r <= cmd_data_i[0];
      if (accept && is_wr && (ofs == `MF_CFG_SCRATCH_OFS))
        scratch_r <= cmd_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_hdr_r  <= cmd_hdr_i;
      resp_data_r <= is_wr ? '0 : rd_data;
    end
  end

  assign resp_v_o    = resp_v_r;
  assign resp_hdr_o  = resp_hdr_r;
  assign resp_data_o = resp_data_r;
  assign freeze_o    = freeze_r;

endmodule

//--- hdl/clint_slice.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module clint_slice
  import mem_fabric_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_hdr_s                  cmd_hdr_i,
  input  logic [`MF_DATA_WIDTH-1:0] cmd_data_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  output mem_hdr_s                  resp_hdr_o,
  output logic [`MF_DATA_WIDTH-1:0] resp_data_o,
  output logic                      resp_v_o,
  input  logic                      resp_yumi_i,
  output logic                      timer_irq_o,
  output logic                      software_irq_o
);

  logic [`MF_DATA_WIDTH-1:0]       mtime_r;
  logic [`MF_DATA_WIDTH-1:0]       mtimecmp_r;
  logic                            msip_r;
  logic                            resp_v_r;
  mem_hdr_s                        resp_hdr_r;
  logic [`MF_DATA_WIDTH-1:0]       resp_data_r;
  logic                            accept;
  logic                            wr_en;
  logic [`MF_DEV_OFFSET_WIDTH-1:0] ofs;
  logic [`MF_DATA_WIDTH-1:0]       rd_data;

  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & ~resp_v_r;
  assign wr_en       = accept & (cmd_hdr_i.opcode == e_mem_wr);
  assign ofs         = cmd_hdr_i.addr.loc.offset;

  always_comb
  begin
    case (ofs)
      `MF_CLINT_MSIP_OFS:     rd_data = {{(`MF_DATA_WIDTH-1){1'b0}}, msip_r};
      `MF_CLINT_MTIMECMP_OFS: rd_data = mtimecmp_r;
      `MF_CLINT_MTIME_OFS:    rd_data = mtime_r;
      default:                rd_data = '0;
    endcase
  end

  // ==============================
  // Timer and software interrupt state
  // ==============================
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r   <= 1'b0;
      mtime_r    <= '0;
      mtimecmp_r <= '1;   // No timer interrupt until programmed
      msip_r     <= 1'b0;
    end
    else
    begin
      resp_v_r <= (resp_v_r & ~resp_yumi_i) | accept;
      if (wr_en && (ofs == `MF_CLINT_MTIME_OFS))
        mtime_r <= cmd_data_i;
      else
        mtime_r <= mtime_r + 1'b1;   // Free-running tick
      if (wr_en && (ofs == `MF_CLINT_MTIMECMP_OFS))
        mtimecmp_r <= cmd_data_i;
      if (wr_en && (ofs == `MF_CLINT_MSIP_OFS))
        msip_r <= cmd_data_i[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_hdr_r  <= cmd_hdr_i;
      resp_data_r <= wr_en ? '0 : rd_data;
    end
  end

  assign resp_v_o       = resp_v_r;
  assign resp_hdr_o     = resp_hdr_r;
  assign resp_data_o    = resp_data_r;
  assign timer_irq_o    = mtime_r >= mtimecmp_r;
  assign software_irq_o = msip_r;

endmodule

//--- hdl/mem_cmd_demux.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module mem_cmd_demux
  import mem_fabric_pkg::*;
(
  input  mem_hdr_s cmd_hdr_i,
  input  logic     cmd_v_i,
  output logic     ext_v_o,
  output logic     cfg_v_o,
  output logic     clint_v_o,
  output logic     loop_v_o
);

  logic                        is_local;
  logic [`MF_DEV_ID_WIDTH-1:0] dev_id;
  logic                        is_cfg;
  logic                        is_clint;
  logic                        is_ext;
  logic                        is_loop;

  assign is_local = cmd_hdr_i.addr.flat < `MF_DRAM_BASE;
  assign dev_id   = cmd_hdr_i.addr.loc.dev_id;

  // ==============================
  // Local map decode
  // ==============================
  assign is_cfg   = is_local & (dev_id == `MF_CFG_DEV);
  assign is_clint = is_local & (dev_id == `MF_CLINT_DEV);
  assign is_ext   = ~is_local | (dev_id == `MF_CACHE_DEV);   // Cache id goes out too
  assign is_loop  = is_local & ~is_cfg & ~is_clint & ~is_ext;

  assign ext_v_o   = cmd_v_i & is_ext;
  assign cfg_v_o   = cmd_v_i & is_cfg;
  assign clint_v_o = cmd_v_i & is_clint;
  assign loop_v_o  = cmd_v_i & is_loop;

endmodule

//--- hdl/mem_fabric_config.svh
`ifndef MEM_FABRIC_CONFIG_SVH
`define MEM_FABRIC_CONFIG_SVH

// ==============================
// Message widths
// ==============================
`define MF_ADDR_WIDTH         32
`define MF_DATA_WIDTH         64
`define MF_DRAM_BASE          32'h8000_0000   // First external address
`define MF_DEV_OFFSET_WIDTH   20
`define MF_DEV_ID_WIDTH       4

// ==============================
// Local map
// ==============================
`define MF_CLINT_DEV          4'd1
`define MF_CFG_DEV            4'd2
`define MF_CACHE_DEV          4'd3            // Routed to external memory
`define MF_CFG_FREEZE_OFS     20'h0_0000
`define MF_CFG_SCRATCH_OFS    20'h0_0008
`define MF_CLINT_MSIP_OFS     20'h0_0000
`define MF_CLINT_MTIMECMP_OFS 20'h0_4000
`define MF_CLINT_MTIME_OFS    20'h0_BFF8

`endif

//--- hdl/mem_fabric_pkg.sv
`include "mem_fabric_config.svh"

package mem_fabric_pkg;

  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_opcode_e;

  // Flat view for range checks, local view for device decode
  typedef union packed
  {
    logic [`MF_ADDR_WIDTH-1:0] flat;
    struct packed
    {
      logic [`MF_ADDR_WIDTH-`MF_DEV_ID_WIDTH-`MF_DEV_OFFSET_WIDTH-1:0] upper;
      logic [`MF_DEV_ID_WIDTH-1:0]                                     dev_id;
      logic [`MF_DEV_OFFSET_WIDTH-1:0]                                 offset;
    } loc;
  } mem_addr_u;

  typedef struct packed
  {
    mem_opcode_e opcode;
    mem_addr_u   addr;
  } mem_hdr_s;

endpackage

//--- hdl/mem_loopback.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module mem_loopback
  import mem_fabric_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_hdr_s                  cmd_hdr_i,
  input  logic [`MF_DATA_WIDTH-1:0] cmd_data_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  output mem_hdr_s                  resp_hdr_o,
  output logic [`MF_DATA_WIDTH-1:0] resp_data_o,
  output logic                      resp_v_o,
  input  logic                      resp_yumi_i
);

  logic     resp_v_r;
  mem_hdr_s resp_hdr_r;
  logic     accept;

  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & ~resp_v_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else
      resp_v_r <= (resp_v_r & ~resp_yumi_i) | accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_hdr_r <= cmd_hdr_i;   // Write data is dropped
  end

  assign resp_v_o    = resp_v_r;
  assign resp_hdr_o  = resp_hdr_r;
  assign resp_data_o = '0;   // Unmapped space reads as zero

endmodule

//--- hdl/mem_resp_arbiter.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module mem_resp_arbiter
  import mem_fabric_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  mem_hdr_s [3:0]                resp_hdr_i,
  input  logic [3:0][`MF_DATA_WIDTH-1:0] resp_data_i,
  input  logic [3:0]                    resp_v_i,
  output logic [3:0]                    resp_yumi_o,
  output mem_hdr_s                      out_hdr_o,
  output logic [`MF_DATA_WIDTH-1:0]     out_data_o,
  output logic                          out_v_o,
  input  logic                          out_yumi_i
);

  mem_hdr_s                  fifo_hdr_r  [2];
  logic [`MF_DATA_WIDTH-1:0] fifo_data_r [2];
  logic                      wr_ptr_r;
  logic                      rd_ptr_r;
  logic [1:0]                count_r;
  logic                      fifo_free;
  logic [3:0]                grant;
  mem_hdr_s                  sel_hdr;
  logic [`MF_DATA_WIDTH-1:0] sel_data;
  logic                      push;
  logic                      pop;

  assign fifo_free = count_r != 2'd2;

  // ==============================
  // Fixed-priority grant
  // ==============================
  always_comb
  begin
    grant = '0;
    for (int i = 0; i < 4; i++)
    begin
      if (resp_v_i[i] && (grant == '0) && fifo_free)
        grant[i] = 1'b1;   // Lowest index wins
    end
  end

  always_comb
  begin
    sel_hdr  = resp_hdr_i[0];
    sel_data = resp_data_i[0];
    for (int i = 1; i < 4; i++)
    begin
      if (grant[i])
      begin
        sel_hdr  = resp_hdr_i[i];
        sel_data = resp_data_i[i];
      end
    end
  end

  assign resp_yumi_o = grant;
  assign push        = |grant;
  assign pop         = out_yumi_i;

  // ==============================
  // Two-entry FIFO
  // ==============================
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= ~wr_ptr_r;
      if (pop)
        rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      fifo_hdr_r[wr_ptr_r]  <= sel_hdr;
      fifo_data_r[wr_ptr_r] <= sel_data;
    end
  end

  assign out_v_o    = count_r != 2'd0;
  assign out_hdr_o  = fifo_hdr_r[rd_ptr_r];
  assign out_data_o = fifo_data_r[rd_ptr_r];

endmodule

//--- hdl/tile_mem_fabric.sv
`timescale 1ns/1ps
`include "mem_fabric_config.svh"

module tile_mem_fabric
  import mem_fabric_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  mem_hdr_s                  mem_cmd_hdr_i,
  input  logic [`MF_DATA_WIDTH-1:0] mem_cmd_data_i,
  input  logic                      mem_cmd_v_i,
  output logic                      mem_cmd_ready_o,
  output mem_hdr_s                  mem_resp_hdr_o,
  output logic [`MF_DATA_WIDTH-1:0] mem_resp_data_o,
  output logic                      mem_resp_v_o,
  input  logic                      mem_resp_yumi_i,
  output mem_hdr_s                  ext_cmd_hdr_o,
  output logic [`MF_DATA_WIDTH-1:0] ext_cmd_data_o,
  output logic                      ext_cmd_v_o,
  input  logic                      ext_cmd_ready_i,
  input  mem_hdr_s                  ext_resp_hdr_i,
  input  logic [`MF_DATA_WIDTH-1:0] ext_resp_data_i,
  input  logic                      ext_resp_v_i,
  output logic                      ext_resp_yumi_o,
  output logic                      freeze_o,
  output logic                      timer_irq_o,
  output logic                      software_irq_o
);

  logic                      cfg_v, clint_v, loop_v;
  logic                      cfg_ready, clint_ready, loop_ready;
  mem_hdr_s                  cfg_hdr, clint_hdr, loop_hdr;
  logic [`MF_DATA_WIDTH-1:0] cfg_data, clint_data, loop_data;
  logic                      cfg_resp_v, clint_resp_v, loop_resp_v;
  logic                      cfg_yumi, clint_yumi, loop_yumi;

  // ==============================
  // Command steering
  // ==============================
  mem_cmd_demux demux
    (.cmd_hdr_i(mem_cmd_hdr_i), .cmd_v_i(mem_cmd_v_i), .ext_v_o(ext_cmd_v_o)
     ,.cfg_v_o(cfg_v), .clint_v_o(clint_v), .loop_v_o(loop_v));

  assign mem_cmd_ready_o = &{ext_cmd_ready_i, cfg_ready, clint_ready, loop_ready};
  assign ext_cmd_hdr_o   = mem_cmd_hdr_i;
  assign ext_cmd_data_o  = mem_cmd_data_i;

  cfg_regs cfg
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.cmd_hdr_i(mem_cmd_hdr_i), .cmd_data_i(mem_cmd_data_i), .cmd_v_i(cfg_v)
     ,.cmd_ready_o(cfg_ready), .resp_hdr_o(cfg_hdr), .resp_data_o(cfg_data)
     ,.resp_v_o(cfg_resp_v), .resp_yumi_i(cfg_yumi), .freeze_o(freeze_o));

  clint_slice clint
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.cmd_hdr_i(mem_cmd_hdr_i), .cmd_data_i(mem_cmd_data_i), .cmd_v_i(clint_v)
     ,.cmd_ready_o(clint_ready), .resp_hdr_o(clint_hdr), .resp_data_o(clint_data)
     ,.resp_v_o(clint_resp_v), .resp_yumi_i(clint_yumi)
     ,.timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o));

  mem_loopback loopback
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.cmd_hdr_i(mem_cmd_hdr_i), .cmd_data_i(mem_cmd_data_i), .cmd_v_i(loop_v)
     ,.cmd_ready_o(loop_ready), .resp_hdr_o(loop_hdr), .resp_data_o(loop_data)
     ,.resp_v_o(loop_resp_v), .resp_yumi_i(loop_yumi));

  // Requester 0 is the external port
  mem_resp_arbiter resp_arb
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.resp_hdr_i({loop_hdr, clint_hdr, cfg_hdr, ext_resp_hdr_i})
     ,.resp_data_i({loop_data, clint_data, cfg_data, ext_resp_data_i})
     ,.resp_v_i({loop_resp_v, clint_resp_v, cfg_resp_v, ext_resp_v_i})
     ,.resp_yumi_o({loop_yumi, clint_yumi, cfg_yumi, ext_resp_yumi_o})
     ,.out_hdr_o(mem_resp_hdr_o), .out_data_o(mem_resp_data_o)
     ,.out_v_o(mem_resp_v_o), .out_yumi_i(mem_resp_yumi_i));

endmodule

//--- tile_mem_fabric.f
+incdir+hdl
hdl/mem_fabric_pkg.sv
hdl/mem_cmd_demux.sv
hdl/mem_resp_arbiter.sv
hdl/cfg_regs.sv
hdl/clint_slice.sv
hdl/mem_loopback.sv
hdl/tile_mem_fabric.sv
dv/mem_fabric_assertions.sv
dv/mem_fabric_checker.sv
dv/tb_tile_mem_fabric.sv
